//--- all.f
source/spidergon_pkg.sv
source/flit_buffer.sv
source/route_select.sv
source/link_register.sv
source/spidergon_node.sv
source/spidergon_top.sv
verification/spidergon_tb.sv

//--- Makefile
# Verilator build and run of the spidergon testbench; every variable can be set on the command line
VERILATOR ?= verilator
TOP ?= spidergon_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and the variables"
	@echo "  test   build and run the testbench, then search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/spidergon_tb.sv
// testbench for spidergon_top; runs single-flit latency sweeps and random all-to-all traffic
`timescale 1ns/1ps
`default_nettype none

module spidergon_tb;

	localparam int N = spidergon_pkg::NUM_OF_NODES;
	localparam int IDW = spidergon_pkg::NODE_ID_WIDTH;
	localparam int DW = spidergon_pkg::FLIT_DATA_WIDTH;
	localparam int FLITS_PER_NODE = 40;
	localparam int SLOTS = 64;
	localparam int TOTAL_FLITS = N * (N - 1) + N * FLITS_PER_NODE;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_FLITS + 200;

	logic clk = 1'b0;
	logic reset;
	spidergon_pkg::flit_t [N-1:0] inject_flit;
	logic [N-1:0] inject_valid;
	logic [N-1:0] inject_ready;
	spidergon_pkg::flit_t [N-1:0] eject_flit;
	logic [N-1:0] eject_valid;
	logic [N-1:0] eject_ready;
	logic [N-1:0] eject_fire;

	// scoreboard, indexed [src][dest]
	int tx_count [N][N];
	int rx_count [N][N];
	int next_seq [N][N];
	logic [DW-1:0] sent_mem [N][N][SLOTS];
	int tx_total = 0;
	int rx_total = 0;

	int cycle_count = 0;
	int inject_cycle = 0;
	int exp_latency = 0;
	logic single_mode = 1'b0;
	logic end_check = 1'b0;
	logic [N-1:0] stalled = '0;
	spidergon_pkg::flit_t [N-1:0] held_flit;
	logic [DW-1:0] exp_payload [N];
	logic [7:0] exp_seq [N];
	logic [N-1:0] was_sent;

	logic [31:0] lcg_state = 32'd63;
	int mismatch_count = 0;
	int error_count = 0;

	spidergon_top #(.BUFFER_DEPTH(2)) dut
	(
		.clk(clk),
		.reset(reset),
		.inject_flit(inject_flit),
		.inject_valid(inject_valid),
		.inject_ready(inject_ready),
		.eject_flit(eject_flit),
		.eject_valid(eject_valid),
		.eject_ready(eject_ready)
	);

	always #10 clk = ~clk;

	assign eject_fire = eject_valid & eject_ready;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// walk the ring by the relative-distance rule and count the links taken
	function automatic int hop_count(input int src, input int dest);
		int node;
		int rel;
		int hops;
		node = src;
		hops = 0;
		while (node != dest && hops < N)
		begin
			rel = (dest - node + N) % N;
			if (rel <= N / 4)
				node = (node + 1) % N;
			else if (rel >= 3 * N / 4)
				node = (node + N - 1) % N;
			else
				node = (node + N / 2) % N;
			hops++;
		end
		return hops;
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("MISMATCH %s expected 0x%0h actual 0x%0h", test, expected, actual);
		mismatch_count++;
	endtask

	task automatic report_error(input string text);
		$display("ERROR %s", text);
		error_count++;
	endtask

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// records every inject and eject transfer at the edge where it happens
	always @(posedge clk)
	begin
		int s;
		int d;
		int tx_add;
		int rx_add;
		tx_add = 0;
		rx_add = 0;
		for (int n = 0; n < N; n++)
		begin
			if (inject_valid[n] && inject_ready[n])
			begin
				d = int'(inject_flit[n].dest);
				sent_mem[n][d][tx_count[n][d] % SLOTS] <= inject_flit[n].payload;
				tx_count[n][d] <= tx_count[n][d] + 1;
				tx_add++;
				if (single_mode)
				begin
					inject_cycle <= cycle_count;
					exp_latency <= 2 * (hop_count(n, d) + 1);
				end
			end
			if (eject_fire[n])
			begin
				s = int'(eject_flit[n].src);
				rx_count[s][n] <= rx_count[s][n] + 1;
				rx_add++;
			end
			stalled[n] <= eject_valid[n] && !eject_ready[n];
			held_flit[n] <= eject_flit[n];
		end
		tx_total <= tx_total + tx_add;
		rx_total <= rx_total + rx_add;
	end

	// what each node should eject next from the source it names
	always_comb
	begin
		int s;
		for (int n = 0; n < N; n++)
		begin
			s = int'(eject_flit[n].src);
			exp_payload[n] = sent_mem[s][n][rx_count[s][n] % SLOTS];
			exp_seq[n] = 8'(rx_count[s][n]);
			was_sent[n] = rx_count[s][n] < tx_count[s][n];
		end
	end

	assert property (@(posedge clk) $fell(reset) |-> eject_valid == '0)
		else report_mismatch("reset_eject_valid", 32'd0, 32'($sampled(eject_valid)));
	assert property (@(posedge clk) $fell(reset) |-> inject_ready == '1)
		else report_mismatch("reset_inject_ready", 32'({N{1'b1}}), 32'($sampled(inject_ready)));

	// only one flit is in flight in this mode
	assert property (@(posedge clk) disable iff (reset)
		single_mode && $rose(|eject_valid) |-> cycle_count - inject_cycle == exp_latency)
		else report_mismatch("zero_load_latency", 32'($sampled(exp_latency)),
			32'($sampled(cycle_count - inject_cycle)));

	assert property (@(posedge clk) end_check |-> eject_valid == '0)
		else report_mismatch("final_eject_valid", 32'd0, 32'($sampled(eject_valid)));

	for (genvar g = 0; g < N; g++)
	begin : g_node_check
		assert property (@(posedge clk) disable iff (reset)
			eject_fire[g] |-> int'(eject_flit[g].dest) == g)
			else report_mismatch("destination", 32'(g), 32'($sampled(eject_flit[g].dest)));
		assert property (@(posedge clk) disable iff (reset) eject_fire[g] |-> was_sent[g])
			else report_error($sformatf("node %0d ejected a flit that was never sent", g));
		assert property (@(posedge clk) disable iff (reset)
			eject_fire[g] |-> eject_flit[g].payload[7:0] == exp_seq[g])
			else report_mismatch("in_order", 32'($sampled(exp_seq[g])),
				32'($sampled(eject_flit[g].payload[7:0])));
		assert property (@(posedge clk) disable iff (reset)
			eject_fire[g] |-> eject_flit[g].payload == exp_payload[g])
			else report_mismatch("payload", 32'($sampled(exp_payload[g])),
				32'($sampled(eject_flit[g].payload)));
		assert property (@(posedge clk) disable iff (reset) stalled[g] |-> eject_valid[g])
			else report_error($sformatf("node %0d dropped eject_valid before transfer", g));
		assert property (@(posedge clk) disable iff (reset)
			stalled[g] |-> eject_flit[g] == held_flit[g])
			else report_mismatch("backpressure_hold", 32'($sampled(held_flit[g])),
				32'($sampled(eject_flit[g])));
	end

	for (genvar s = 0; s < N; s++)
	begin : g_src
		for (genvar d = 0; d < N; d++)
		begin : g_dest
			assert property (@(posedge clk) end_check |-> rx_count[s][d] == tx_count[s][d])
				else report_mismatch($sformatf("conservation %0d->%0d", s, d),
					32'($sampled(tx_count[s][d])), 32'($sampled(rx_count[s][d])));
		end
	end

	// one flit, then wait until the network has delivered everything
	task automatic send_single(input int src, input int dest);
		spidergon_pkg::flit_t f;
		logic [31:0] r;
		r = next_random();
		f.dest = IDW'(dest);
		f.src = IDW'(src);
		f.payload = {r[23:16], 8'(next_seq[src][dest])};
		next_seq[src][dest]++;
		@(posedge clk);
		inject_flit[src] <= f;
		inject_valid[src] <= 1'b1;
		do @(posedge clk); while (!inject_ready[src]);
		inject_valid[src] <= 1'b0;
		do @(posedge clk); while (rx_total < tx_total);
	endtask

	task automatic run_random_traffic();
		int remaining [N];
		int left;
		int d;
		logic [N-1:0] pending;
		logic [31:0] r;
		spidergon_pkg::flit_t f;
		for (int n = 0; n < N; n++)
			remaining[n] = FLITS_PER_NODE;
		left = N * FLITS_PER_NODE;
		pending = '0;
		while (left > 0 || pending != '0)
		begin
			@(posedge clk);
			for (int n = 0; n < N; n++)
			begin
				if (pending[n] && inject_ready[n])
					pending[n] = 1'b0;
				if (!pending[n])
				begin
					r = next_random();
					if (remaining[n] > 0 && r[31])
					begin
						d = int'((r >> 24) % N);
						f.dest = IDW'(d);
						f.src = IDW'(n);
						f.payload = {r[23:16], 8'(next_seq[n][d])};
						next_seq[n][d]++;
						inject_flit[n] <= f;
						inject_valid[n] <= 1'b1;
						pending[n] = 1'b1;
						remaining[n]--;
						left--;
					end
					else
						inject_valid[n] <= 1'b0;
				end
			end
			// ready about three cycles in four
			r = next_random();
			eject_ready <= N'(r >> 24) | N'(r >> 16);
		end
	endtask

	initial
	begin
		while (cycle_count < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("timeout: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		inject_flit = '0;
		inject_valid = '0;
		eject_ready = '1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		single_mode <= 1'b1;
		for (int s = 0; s < N; s++)
		begin
			for (int d = 0; d < N; d++)
			begin
				if (s != d)
					send_single(s, d);
			end
		end
		single_mode <= 1'b0;
		run_random_traffic();
		eject_ready <= '1;
		do @(posedge clk); while (rx_total < tx_total);
		end_check <= 1'b1;
		@(posedge clk);
		end_check <= 1'b0;
		@(posedge clk);
		$display("errors: %0d mismatches, %0d other failures, %0d flits delivered",
			mismatch_count, error_count, rx_total);
		if (mismatch_count == 0 && error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/spidergon_top.sv
// eight-node spidergon network with ring and across links; per-node inject and eject ports
`timescale 1ns/1ps
`default_nettype none

module spidergon_top
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t [spidergon_pkg::NUM_OF_NODES-1:0] inject_flit,
	input logic [spidergon_pkg::NUM_OF_NODES-1:0] inject_valid,
	output logic [spidergon_pkg::NUM_OF_NODES-1:0] inject_ready,
	output spidergon_pkg::flit_t [spidergon_pkg::NUM_OF_NODES-1:0] eject_flit,
	output logic [spidergon_pkg::NUM_OF_NODES-1:0] eject_valid,
	input logic [spidergon_pkg::NUM_OF_NODES-1:0] eject_ready
);

	localparam int N = spidergon_pkg::NUM_OF_NODES;
	localparam int P = spidergon_pkg::NUM_OF_PORTS;

	spidergon_pkg::flit_t [N-1:0][P-1:0] node_in_flit;
	spidergon_pkg::flit_t [N-1:0][P-1:0] node_out_flit;
	logic [N-1:0][P-1:0] node_in_valid;
	logic [N-1:0][P-1:0] node_in_ready;
	logic [N-1:0][P-1:0] node_out_valid;
	logic [N-1:0][P-1:0] node_out_ready;

	for (genvar n = 0; n < N; n++)
	begin : g_node
		localparam int NEXT = (n + 1) % N;
		localparam int PREV = (n + N - 1) % N;
		localparam int OPPOSITE = (n + N / 2) % N;

		// anticlockwise input comes from the clockwise output of the previous node
		assign node_in_flit[n][spidergon_pkg::port_anticlockwise] =
			node_out_flit[PREV][spidergon_pkg::port_clockwise];
		assign node_in_valid[n][spidergon_pkg::port_anticlockwise] =
			node_out_valid[PREV][spidergon_pkg::port_clockwise];
		assign node_out_ready[n][spidergon_pkg::port_anticlockwise] =
			node_in_ready[PREV][spidergon_pkg::port_clockwise];

		assign node_in_flit[n][spidergon_pkg::port_clockwise] =
			node_out_flit[NEXT][spidergon_pkg::port_anticlockwise];
		assign node_in_valid[n][spidergon_pkg::port_clockwise] =
			node_out_valid[NEXT][spidergon_pkg::port_anticlockwise];
		assign node_out_ready[n][spidergon_pkg::port_clockwise] =
			node_in_ready[NEXT][spidergon_pkg::port_anticlockwise];

		// across links pair node n with node n + N/2 in both directions
		assign node_in_flit[n][spidergon_pkg::port_across] =
			node_out_flit[OPPOSITE][spidergon_pkg::port_across];
		assign node_in_valid[n][spidergon_pkg::port_across] =
			node_out_valid[OPPOSITE][spidergon_pkg::port_across];
		assign node_out_ready[n][spidergon_pkg::port_across] =
			node_in_ready[OPPOSITE][spidergon_pkg::port_across];

		assign node_in_flit[n][spidergon_pkg::port_local] = inject_flit[n];
		assign node_in_valid[n][spidergon_pkg::port_local] = inject_valid[n];
		assign inject_ready[n] = node_in_ready[n][spidergon_pkg::port_local];
		assign eject_flit[n] = node_out_flit[n][spidergon_pkg::port_local];
		assign eject_valid[n] = node_out_valid[n][spidergon_pkg::port_local];
		assign node_out_ready[n][spidergon_pkg::port_local] = eject_ready[n];

		spidergon_node #(.NODE_ID(n), .BUFFER_DEPTH(BUFFER_DEPTH)) u_node
		(
			.clk(clk),
			.reset(reset),
			.in_flit(node_in_flit[n]),
			.in_valid(node_in_valid[n]),
			.in_ready(node_in_ready[n]),
			.out_flit(node_out_flit[n]),
			.out_valid(node_out_valid[n]),
			.out_ready(node_out_ready[n])
		);
	end

endmodule

`default_nettype wire

//--- source/spidergon_node.sv
// one spidergon router with input FIFOs, route selection and output link registers per port
`timescale 1ns/1ps
`default_nettype none

module spidergon_node
#(
	parameter int NODE_ID = 0,
	parameter int BUFFER_DEPTH = 2
)
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t [spidergon_pkg::NUM_OF_PORTS-1:0] in_flit,
	input logic [spidergon_pkg::NUM_OF_PORTS-1:0] in_valid,
	output logic [spidergon_pkg::NUM_OF_PORTS-1:0] in_ready,
	output spidergon_pkg::flit_t [spidergon_pkg::NUM_OF_PORTS-1:0] out_flit,
	output logic [spidergon_pkg::NUM_OF_PORTS-1:0] out_valid,
	input logic [spidergon_pkg::NUM_OF_PORTS-1:0] out_ready
);

	spidergon_pkg::flit_t [spidergon_pkg::NUM_OF_PORTS-1:0] head_flit;
	logic [spidergon_pkg::NUM_OF_PORTS-1:0] head_valid;
	logic [spidergon_pkg::NUM_OF_PORTS-1:0] pop;

	spidergon_pkg::flit_t [spidergon_pkg::NUM_OF_PORTS-1:0] load_flit;
	logic [spidergon_pkg::NUM_OF_PORTS-1:0] out_free;
	logic [spidergon_pkg::NUM_OF_PORTS-1:0] out_load;

	// buffer and link register of each direction
	for (genvar p = 0; p < spidergon_pkg::NUM_OF_PORTS; p++)
	begin : g_port
		flit_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_buffer
		(
			.clk(clk),
			.reset(reset),
			.in_flit(in_flit[p]),
			.in_valid(in_valid[p]),
			.in_ready(in_ready[p]),
			.head_flit(head_flit[p]),
			.head_valid(head_valid[p]),
			.pop(pop[p])
		);

		link_register u_link
		(
			.clk(clk),
			.reset(reset),
			.load(out_load[p]),
			.load_flit(load_flit[p]),
			.free(out_free[p]),
			.out_flit(out_flit[p]),
			.out_valid(out_valid[p]),
			.out_ready(out_ready[p])
		);
	end

	route_select #(.NODE_ID(NODE_ID)) u_route
	(
		.clk(clk),
		.reset(reset),
		.head_flit(head_flit),
		.head_valid(head_valid),
		.pop(pop),
		.out_free(out_free),
		.out_load(out_load),
		.out_flit(load_flit)
	);

endmodule

`default_nettype wire

//--- source/link_register.sv
// output stage of one router port; holds a flit on the link until the receiver takes it
`timescale 1ns/1ps
`default_nettype none

module link_register
(
	input logic clk,
	input logic reset,
	input logic load,
	input spidergon_pkg::flit_t load_flit,
	output logic free,
	output spidergon_pkg::flit_t out_flit,
	output logic out_valid,
	input logic out_ready
);

	// empty, or emptied by the transfer at this edge
	assign free = !out_valid || out_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			out_flit <= load_flit;
	end

	// a waiting flit must not change or vanish before the receiver sees it
	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_flit))
		else $error("link_register changed a flit that was not yet taken");

	assert property (@(posedge clk) disable iff (reset) load |-> free)
		else $error("link_register loaded while still holding a flit");

endmodule

`default_nettype wire

//--- source/route_select.sv
// routing and round-robin switch allocation of one router; picks a head flit for each free output
`timescale 1ns/1ps
`default_nettype none

module route_select
#(
	parameter int NODE_ID = 0
)
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t [spidergon_pkg::NUM_OF_PORTS-1:0] head_flit,
	input logic [spidergon_pkg::NUM_OF_PORTS-1:0] head_valid,
	output logic [spidergon_pkg::NUM_OF_PORTS-1:0] pop,
	input logic [spidergon_pkg::NUM_OF_PORTS-1:0] out_free,
	output logic [spidergon_pkg::NUM_OF_PORTS-1:0] out_load,
	output spidergon_pkg::flit_t [spidergon_pkg::NUM_OF_PORTS-1:0] out_flit
);

	localparam int NUM_PORTS = spidergon_pkg::NUM_OF_PORTS;
	localparam int PTR_WIDTH = $clog2(NUM_PORTS);
	localparam int QUARTER = spidergon_pkg::NUM_OF_NODES / 4;

	spidergon_pkg::port_e head_dir [NUM_PORTS];

	// grant[o][i] gives output o to input i
	logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant;
	logic [NUM_PORTS-1:0][PTR_WIDTH-1:0] grant_idx;

	// input with the highest priority at each output
	logic [NUM_PORTS-1:0][PTR_WIDTH-1:0] rr_ptr;

	// direction from the distance to the destination, measured clockwise
	function automatic spidergon_pkg::port_e route_dir
	(
		input logic [spidergon_pkg::NODE_ID_WIDTH-1:0] dest
	);
		int rel;
		rel = (int'(dest) + spidergon_pkg::NUM_OF_NODES - NODE_ID) % spidergon_pkg::NUM_OF_NODES;
		if (rel == 0)
			return spidergon_pkg::port_local;
		if (rel <= QUARTER)
			return spidergon_pkg::port_clockwise;
		if (rel >= 3 * QUARTER)
			return spidergon_pkg::port_anticlockwise;
		return spidergon_pkg::port_across;
	endfunction

	always_comb
	begin
		for (int i = 0; i < NUM_PORTS; i++)
			head_dir[i] = route_dir(head_flit[i].dest);
	end

	// scan the inputs starting at the pointer and take the first one that asks
	always_comb
	begin
		int idx;
		logic found;
		grant = '0;
		grant_idx = '0;
		out_flit = '0;
		for (int o = 0; o < NUM_PORTS; o++)
		begin
			found = 1'b0;
			for (int k = 0; k < NUM_PORTS; k++)
			begin
				idx = (int'(rr_ptr[o]) + k) % NUM_PORTS;
				if (!found && out_free[o] && head_valid[idx] &&
					head_dir[idx] == spidergon_pkg::port_e'(o))
				begin
					found = 1'b1;
					grant[o][idx] = 1'b1;
					grant_idx[o] = PTR_WIDTH'(idx);
					out_flit[o] = head_flit[idx];
				end
			end
		end
	end

	always_comb
	begin
		pop = '0;
		for (int o = 0; o < NUM_PORTS; o++)
		begin
			out_load[o] = |grant[o];
			pop = pop | grant[o];
		end
	end

	// winner drops to lowest priority for its output
	always_ff @(posedge clk)
	begin
		if (reset)
			rr_ptr <= '0;
		else
		begin
			for (int o = 0; o < NUM_PORTS; o++)
			begin
				if (out_load[o])
					rr_ptr[o] <= grant_idx[o] + 1'b1;
			end
		end
	end

	for (genvar g = 0; g < NUM_PORTS; g++)
	begin : g_grant_check
		assert property (@(posedge clk) disable iff (reset) $onehot0(grant[g]))
			else $error("route_select output %0d granted to more than one input", g);
	end

	// an input taken by two outputs would show up as fewer pops than grants
	assert property (@(posedge clk) disable iff (reset) $countones(grant) == $countones(pop))
		else $error("route_select popped one input for two outputs");

endmodule

`default_nettype wire

//--- source/flit_buffer.sv
// input FIFO of one router port; accepts flits while it has space and shows the oldest at its head
`timescale 1ns/1ps
`default_nettype none

module flit_buffer
#(
	parameter int BUFFER_DEPTH = 2
)
(
	input logic clk,
	input logic reset,
	input spidergon_pkg::flit_t in_flit,
	input logic in_valid,
	output logic in_ready,
	output spidergon_pkg::flit_t head_flit,
	output logic head_valid,
	input logic pop
);

	localparam int PTR_WIDTH = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(BUFFER_DEPTH + 1);

	spidergon_pkg::flit_t mem [BUFFER_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic push;

	// wraps at the depth, which need not be a power of two
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(BUFFER_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign in_ready = (count < COUNT_WIDTH'(BUFFER_DEPTH));
	assign push = in_valid && in_ready;
	assign head_valid = (count != '0);
	assign head_flit = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_flit;
	end

	// the route selector may only take a flit that is really here
	assert property (@(posedge clk) disable iff (reset) pop |-> head_valid)
		else $error("flit_buffer popped while empty");

endmodule

`default_nettype wire

//--- source/spidergon_pkg.sv
// shared constants, port directions and flit format for the spidergon network; compile this first
`default_nettype none

package spidergon_pkg;

	// ring size, a multiple of four so that every node has a partner across the ring
	localparam int NUM_OF_NODES = 8;

	localparam int NODE_ID_WIDTH = $clog2(NUM_OF_NODES);

	// payload bits carried by every flit
	localparam int FLIT_DATA_WIDTH = 16;

	// anticlockwise, clockwise, across and local
	localparam int NUM_OF_PORTS = 4;

	// router port directions
	// the value is also the index into every per-port array of a node
	typedef enum logic [1:0]
	{
		port_anticlockwise = 2'd0,
		port_clockwise = 2'd1,
		port_across = 2'd2,
		port_local = 2'd3
	} port_e;

	// single-flit packet
	// dest is the top field so routing only looks at the upper bits
	typedef struct packed
	{
		logic [NODE_ID_WIDTH-1:0] dest;
		logic [NODE_ID_WIDTH-1:0] src;
		logic [FLIT_DATA_WIDTH-1:0] payload;
	} flit_t;

endpackage

`default_nettype wire
